// File: Makefile
SOURCES := $(shell grep -v '^+' verilog.f) hw/icache_defs.svh

obj_dir/Vifetch_tb: verilog.f $(SOURCES)
	verilator --binary --timing --assert --top-module ifetch_tb -f verilog.f

run: obj_dir/Vifetch_tb
	./obj_dir/Vifetch_tb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: bench/ifetch_tb.sv
// Instruction fetch testbench

`timescale 1ns/1ns

module ifetch_tb;

    localparam int NUM_ENTRIES = 7;
    localparam int WAIT_LIMIT  = 200;

    // Redirect target, instructions to take, line reads expected, last line read
    typedef struct packed {
        icache_pkg::addr_t pc;
        int                count;
        int                reads;
        icache_pkg::addr_t line;
    } entry_t;

    logic              clk;
    logic              arst_n;
    logic              redirect_en;
    icache_pkg::addr_t redirect_pc;
    logic              insn_valid;
    icache_pkg::addr_t insn_pc;
    icache_pkg::insn_t insn;
    logic              mem_rd_en;
    icache_pkg::addr_t mem_rd_addr;
    logic              mem_rd_valid;
    icache_pkg::line_t mem_rd_line;

    entry_t            stim_table [NUM_ENTRIES];
    int                errors;
    int                checks;
    int                tests;
    int                rd_count = 0;
    icache_pkg::addr_t last_rd_addr = '0;
    logic              timed_out;

    ifetch_top ifetch_top_inst (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_redirect_en  (redirect_en),
        .i_redirect_pc  (redirect_pc),
        .o_insn_valid   (insn_valid),
        .o_insn_pc      (insn_pc),
        .o_insn         (insn),
        .o_mem_rd_en    (mem_rd_en),
        .o_mem_rd_addr  (mem_rd_addr),
        .i_mem_rd_valid (mem_rd_valid),
        .i_mem_rd_line  (mem_rd_line)
    );

    line_memory #(.SEED(78)) line_memory_inst (
        .clk        (clk),
        .i_rd_en    (mem_rd_en),
        .i_rd_addr  (mem_rd_addr),
        .o_rd_valid (mem_rd_valid),
        .o_rd_line  (mem_rd_line)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Line reads issued so far and the last line asked for
    always @(negedge clk) begin
        if (mem_rd_en) begin
            rd_count     <= rd_count + 1;
            last_rd_addr <= mem_rd_addr;
        end
    end

    function automatic icache_pkg::insn_t expected_word(input icache_pkg::addr_t pc);
        return {~pc[31:16], pc[15:0]};
    endfunction

    task automatic check_addr(input string name, input icache_pkg::addr_t got,
                              input icache_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_insn(input string name, input icache_pkg::insn_t got,
                              input icache_pkg::insn_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // One-cycle redirect strobe
    task automatic send_redirect(input icache_pkg::addr_t pc);
        @(negedge clk);
        redirect_en = 1'b1;
        redirect_pc = pc;
        @(negedge clk);
        redirect_en = 1'b0;
    endtask

    task automatic wait_insn(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = insn_valid;
            n++;
        end
    endtask

    task automatic run_entry(input int t);
        int                start_errors;
        int                start_reads;
        logic              seen;
        icache_pkg::addr_t pc;
        start_errors = errors;
        start_reads  = rd_count;
        send_redirect(stim_table[t].pc);
        for (int k = 0; k < stim_table[t].count && !timed_out; k++) begin
            pc = stim_table[t].pc + icache_pkg::addr_t'(4 * k);
            wait_insn(seen);
            if (!seen) begin
                timed_out = 1'b1;
                errors++;
                $display("Test %0d timed out waiting for the instruction at %h", t, pc);
            end else begin
                check_addr("o_insn_pc", insn_pc, pc);
                check_insn("o_insn", insn, expected_word(pc));
            end
        end
        if (!timed_out) begin
            check_count("memory reads", rd_count - start_reads, stim_table[t].reads);
            check_addr("o_mem_rd_addr", last_rd_addr, stim_table[t].line);
        end
        tests++;
        $display("Test %0d: redirect to %h, %0d instructions, %s", t, stim_table[t].pc,
                 stim_table[t].count, (errors == start_errors) ? "ok" : "failed");
    endtask

    initial begin
        int idle_valid;
        arst_n      = 1'b0;
        redirect_en = 1'b0;
        redirect_pc = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        timed_out   = 1'b0;
        idle_valid  = 0;
        // Lookahead misses at the end of one entry land in the next one
        stim_table[0] = '{pc: 32'h100, count: 8,  reads: 1, line: 32'h100};
        stim_table[1] = '{pc: 32'h100, count: 16, reads: 1, line: 32'h120};
        stim_table[2] = '{pc: 32'h500, count: 8,  reads: 2, line: 32'h500};
        stim_table[3] = '{pc: 32'h100, count: 8,  reads: 2, line: 32'h100};
        stim_table[4] = '{pc: 32'h100, count: 3,  reads: 1, line: 32'h120};
        stim_table[5] = '{pc: 32'h040, count: 8,  reads: 1, line: 32'h040};
        stim_table[6] = '{pc: 32'h100, count: 8,  reads: 1, line: 32'h060};

        repeat (3) begin
            @(negedge clk);
            if (insn_valid) idle_valid++;
        end
        arst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (insn_valid) idle_valid++;
        end
        check_count("o_insn_valid pulses", idle_valid, 0);
        check_count("memory reads", rd_count, 0);
        tests++;
        $display("Test reset: %s", (errors == 0) ? "ok" : "failed");

        for (int t = 0; t < NUM_ENTRIES && !timed_out; t++) begin
            run_entry(t);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: bench/line_memory.sv
// Behavioral line memory

`timescale 1ns/1ns

// Answers each line read once, after 1 to 8 cycles
module line_memory #(
    parameter int SEED = 1
) (
    input  logic              clk,
    input  logic              i_rd_en,
    input  icache_pkg::addr_t i_rd_addr,
    output logic              o_rd_valid,
    output icache_pkg::line_t o_rd_line
);

    // Each word holds its own byte address with the upper half inverted
    function automatic icache_pkg::line_t line_at(input icache_pkg::addr_t line_addr);
        icache_pkg::line_t data;
        icache_pkg::addr_t word_addr;
        data = '0;
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++) begin
            word_addr = line_addr + icache_pkg::addr_t'(4 * w);
            data[w*32 +: 32] = {~word_addr[31:16], word_addr[15:0]};
        end
        return data;
    endfunction

    initial begin
        int unsigned       delay_left;
        logic              busy;
        icache_pkg::addr_t req_addr;
        void'($urandom(SEED));
        delay_left = 0;
        busy       = 1'b0;
        req_addr   = '0;
        o_rd_valid = 1'b0;
        o_rd_line  = '0;
        forever begin
            @(negedge clk);
            o_rd_valid = 1'b0;
            if (busy) begin
                delay_left = delay_left - 1;
                if (delay_left == 0) begin
                    o_rd_valid = 1'b1;
                    o_rd_line  = line_at(req_addr);
                    busy       = 1'b0;
                end
            end else if (i_rd_en) begin
                busy       = 1'b1;
                req_addr   = i_rd_addr;
                delay_left = $urandom_range(8, 1);
            end
        end
    end

endmodule

// File: hw/cache_array.sv
// Direct-mapped cache storage

`timescale 1ns/1ns

module cache_array (
    input  logic               clk,
    input  logic               i_arst_n,

    input  logic               i_rd_en,
    input  icache_pkg::index_t i_rd_index,

    input  icache_pkg::fill_t  i_wr,

    output logic               o_rd_valid,
    output icache_pkg::tag_t   o_rd_tag,
    output icache_pkg::line_t  o_rd_line
);

    // One valid bit per line
    logic [icache_pkg::NUM_LINES-1:0] valid_r;

    icache_pkg::tag_t  tag_mem  [icache_pkg::NUM_LINES];
    icache_pkg::line_t line_mem [icache_pkg::NUM_LINES];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_r <= '0;
        end else if (i_wr.en) begin
            valid_r[i_wr.index] <= 1'b1;
        end
    end

    // Tag and line write
    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            tag_mem[i_wr.index]  <= i_wr.tag;
            line_mem[i_wr.index] <= i_wr.line;
        end
    end

    // Synchronous read returns the old contents on a same-index write
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rd_valid <= 1'b0;
        end else if (i_rd_en) begin
            o_rd_valid <= valid_r[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_tag  <= tag_mem[i_rd_index];
            o_rd_line <= line_mem[i_rd_index];
        end
    end

    // A fill from the miss unit always names a known line
    wr_index_known: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_wr.en |-> !$isunknown(i_wr.index)
    );

endmodule

// File: hw/fetch_pc_gen.sv
// Fetch PC generator

`timescale 1ns/1ns

module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   i_arst_n,

    input  logic                   i_redirect_en,
    input  icache_pkg::addr_t      i_redirect_pc,

    input  logic                   i_stall,
    input  logic                   i_replay,

    input  icache_pkg::fetch_rsp_t i_rsp,
    output logic                   o_lookup_en,
    output icache_pkg::addr_t      o_lookup_addr,

    output logic                   o_insn_valid,
    output icache_pkg::addr_t      o_insn_pc,
    output icache_pkg::insn_t      o_insn
);

    icache_pkg::addr_t pc_r;
    icache_pkg::addr_t pc_it_r;
    icache_pkg::addr_t rewind_pc;
    logic              active_r;
    logic              wait_r;
    // Bit 0 for the lookup in IT, bit 1 for the response now visible
    logic [1:0]        live_r;
    logic              miss_accept;
    logic              kill;

    // Same condition under which the miss unit leaves idle
    assign miss_accept = i_rsp.valid && !i_rsp.hit && !i_stall;
    assign kill        = i_redirect_en || miss_accept;

    // Oldest lookup of the current stream that never completed
    always_comb begin
        if (live_r[1]) begin
            rewind_pc = i_rsp.pc;
        end else if (live_r[0]) begin
            rewind_pc = pc_it_r;
        end else begin
            rewind_pc = pc_r;
        end
    end

    assign o_lookup_en   = active_r && !wait_r;
    assign o_lookup_addr = pc_r;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_r     <= '0;
            active_r <= 1'b0;
            wait_r   <= 1'b0;
            live_r   <= '0;
        end else begin
            live_r <= {live_r[0] && !kill, o_lookup_en && !kill};
            if (i_redirect_en) begin
                active_r <= 1'b1;
            end
            if (miss_accept) begin
                wait_r <= 1'b1;
            end else if (i_replay) begin
                wait_r <= 1'b0;
            end
            // Redirect wins over both a rewind and a pending replay
            if (i_redirect_en) begin
                pc_r <= i_redirect_pc;
            end else if (miss_accept) begin
                pc_r <= rewind_pc;
            end else if (o_lookup_en) begin
                pc_r <= pc_r + icache_pkg::addr_t'(icache_pkg::INSN_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        pc_it_r <= pc_r;
    end

    assign o_insn_valid = i_rsp.valid && i_rsp.hit && live_r[1] && !i_redirect_en;
    assign o_insn_pc    = i_rsp.pc;
    assign o_insn       = i_rsp.insn;

    // Each replay from the miss unit answers a miss we rewound on
    replay_expected: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_replay |-> wait_r
    );

endmodule

// File: hw/icache.sv
// Two-stage instruction cache

`timescale 1ns/1ns

`include "icache_defs.svh"

// IT stage reads the arrays, IR stage resolves the hit and the word
module icache (
    input  logic                   clk,
    input  logic                   i_arst_n,

    input  logic                   i_lookup_en,
    input  icache_pkg::addr_t      i_lookup_addr,

    input  icache_pkg::fill_t      i_fill,

    output icache_pkg::fetch_rsp_t o_rsp,
    output logic                   o_miss_en,
    output icache_pkg::addr_t      o_miss_addr
);

    // Address fields of the lookup
    icache_pkg::tag_t      lookup_tag;
    icache_pkg::index_t    lookup_index;
    icache_pkg::word_sel_t lookup_word_sel;

    assign lookup_tag      = i_lookup_addr[`IC_ADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH];
    assign lookup_index    = i_lookup_addr[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH];
    assign lookup_word_sel =
        i_lookup_addr[icache_pkg::INSN_BYTE_WIDTH +: icache_pkg::WORD_SEL_WIDTH];

    logic              rd_valid;
    icache_pkg::tag_t  rd_tag;
    icache_pkg::line_t rd_line;

    cache_array cache_array_inst (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rd_en    (i_lookup_en),
        .i_rd_index (lookup_index),
        .i_wr       (i_fill),
        .o_rd_valid (rd_valid),
        .o_rd_tag   (rd_tag),
        .o_rd_line  (rd_line)
    );

    // IT stage registers beside the array read
    logic                  it_valid_r;
    icache_pkg::tag_t      it_tag_r;
    icache_pkg::word_sel_t it_word_sel_r;
    icache_pkg::addr_t     it_pc_r;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            it_valid_r <= 1'b0;
        end else begin
            it_valid_r <= i_lookup_en;
        end
    end

    always_ff @(posedge clk) begin
        it_tag_r      <= lookup_tag;
        it_word_sel_r <= lookup_word_sel;
        it_pc_r       <= i_lookup_addr;
    end

    // Hit check and word select
    logic                                              ir_hit;
    icache_pkg::insn_t [icache_pkg::WORDS_PER_LINE-1:0] line_words;

    assign ir_hit     = it_valid_r && rd_valid && (rd_tag == it_tag_r);
    assign line_words = rd_line;

    // IR stage
    logic              rsp_valid_r;
    logic              rsp_hit_r;
    icache_pkg::addr_t rsp_pc_r;
    icache_pkg::insn_t rsp_insn_r;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rsp_valid_r <= 1'b0;
            rsp_hit_r   <= 1'b0;
        end else begin
            rsp_valid_r <= it_valid_r;
            rsp_hit_r   <= ir_hit;
        end
    end

    always_ff @(posedge clk) begin
        rsp_pc_r   <= it_pc_r;
        rsp_insn_r <= line_words[it_word_sel_r];
    end

    always_comb begin
        o_rsp.valid = rsp_valid_r;
        o_rsp.hit   = rsp_hit_r;
        o_rsp.pc    = rsp_pc_r;
        o_rsp.insn  = rsp_insn_r;
    end

    // A valid lookup that missed goes to the miss unit
    assign o_miss_en   = rsp_valid_r && !rsp_hit_r;
    assign o_miss_addr = rsp_pc_r;

endmodule

// File: hw/icache_defs.svh
// Instruction cache sizes

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Fetch address width in bits
`define IC_ADDR_WIDTH 32

// Instruction word width in bits
`define IC_INSN_WIDTH 32

// Total cache capacity in bytes
`define IC_CACHE_SIZE 1024

// Bytes per cache line
`define IC_LINE_SIZE 32

`endif

// File: hw/icache_miss_unit.sv
// Instruction cache miss handler

`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_miss_unit (
    input  logic              clk,
    input  logic              i_arst_n,

    input  logic              i_miss_en,
    input  icache_pkg::addr_t i_miss_addr,

    output logic              o_mem_rd_en,
    output icache_pkg::addr_t o_mem_rd_addr,
    input  logic              i_mem_rd_valid,
    input  icache_pkg::line_t i_mem_rd_line,

    output icache_pkg::fill_t o_fill,
    output logic              o_stall,
    output logic              o_replay
);

    icache_pkg::miss_state_t state_r;
    icache_pkg::miss_state_t state_next;

    // Line being fetched
    icache_pkg::tag_t   miss_tag_r;
    icache_pkg::index_t miss_index_r;
    icache_pkg::line_t  line_r;

    always_comb begin
        state_next = state_r;
        case (state_r)
            icache_pkg::miss_idle: begin
                if (i_miss_en) begin
                    state_next = icache_pkg::miss_request;
                end
            end
            icache_pkg::miss_request:   state_next = icache_pkg::miss_wait_line;
            icache_pkg::miss_wait_line: begin
                if (i_mem_rd_valid) begin
                    state_next = icache_pkg::miss_fill;
                end
            end
            icache_pkg::miss_fill:      state_next = icache_pkg::miss_restart;
            icache_pkg::miss_restart:   state_next = icache_pkg::miss_idle;
            default:                    state_next = icache_pkg::miss_idle;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= icache_pkg::miss_idle;
        end else begin
            state_r <= state_next;
        end
    end

    // Misses seen while busy are dropped here
    always_ff @(posedge clk) begin
        if (state_r == icache_pkg::miss_idle && i_miss_en) begin
            miss_tag_r   <= i_miss_addr[`IC_ADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH];
            miss_index_r <= i_miss_addr[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH];
        end
        if (state_r == icache_pkg::miss_wait_line && i_mem_rd_valid) begin
            line_r <= i_mem_rd_line;
        end
    end

    // Line-aligned request
    assign o_mem_rd_en   = (state_r == icache_pkg::miss_request);
    assign o_mem_rd_addr = {miss_tag_r, miss_index_r, {icache_pkg::OFFSET_WIDTH{1'b0}}};

    always_comb begin
        o_fill.en    = (state_r == icache_pkg::miss_fill);
        o_fill.index = miss_index_r;
        o_fill.tag   = miss_tag_r;
        o_fill.line  = line_r;
    end

    assign o_stall  = (state_r != icache_pkg::miss_idle);
    assign o_replay = (state_r == icache_pkg::miss_restart);

    mem_rd_single: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_mem_rd_en |=> !o_mem_rd_en
    );

    // Memory answers only the request we are waiting on
    mem_rsp_expected: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_mem_rd_valid |-> (state_r == icache_pkg::miss_wait_line)
    );

endmodule

// File: hw/icache_pkg.sv
// Instruction fetch types

`include "icache_defs.svh"

package icache_pkg;

    // Geometry derived from the size macros
    localparam int LINE_WIDTH      = `IC_LINE_SIZE * 8;
    localparam int NUM_LINES       = `IC_CACHE_SIZE / `IC_LINE_SIZE;
    localparam int INDEX_WIDTH     = $clog2(NUM_LINES);
    localparam int OFFSET_WIDTH    = $clog2(`IC_LINE_SIZE);
    localparam int INSN_BYTES      = `IC_INSN_WIDTH / 8;
    localparam int INSN_BYTE_WIDTH = $clog2(INSN_BYTES);
    localparam int WORD_SEL_WIDTH  = OFFSET_WIDTH - INSN_BYTE_WIDTH;
    localparam int WORDS_PER_LINE  = LINE_WIDTH / `IC_INSN_WIDTH;
    localparam int TAG_WIDTH       = `IC_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [`IC_ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`IC_INSN_WIDTH-1:0]  insn_t;
    typedef logic [LINE_WIDTH-1:0]      line_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;
    typedef logic [INDEX_WIDTH-1:0]     index_t;
    typedef logic [WORD_SEL_WIDTH-1:0]  word_sel_t;

    // Write port into the cache arrays
    typedef struct packed {
        logic   en;
        index_t index;
        tag_t   tag;
        line_t  line;
    } fill_t;

    // IR stage result
    typedef struct packed {
        logic  valid;
        logic  hit;
        addr_t pc;
        insn_t insn;
    } fetch_rsp_t;

    typedef enum logic [2:0] {
        miss_idle,
        miss_request,
        miss_wait_line,
        miss_fill,
        miss_restart
    } miss_state_t;

endpackage

// File: hw/ifetch_top.sv
// Instruction fetch front end

`timescale 1ns/1ns

module ifetch_top (
    input  logic              clk,
    input  logic              i_arst_n,

    input  logic              i_redirect_en,
    input  icache_pkg::addr_t i_redirect_pc,

    output logic              o_insn_valid,
    output icache_pkg::addr_t o_insn_pc,
    output icache_pkg::insn_t o_insn,

    output logic              o_mem_rd_en,
    output icache_pkg::addr_t o_mem_rd_addr,
    input  logic              i_mem_rd_valid,
    input  icache_pkg::line_t i_mem_rd_line
);

    logic                   lookup_en;
    icache_pkg::addr_t      lookup_addr;
    icache_pkg::fetch_rsp_t rsp;
    logic                   miss_en;
    icache_pkg::addr_t      miss_addr;
    icache_pkg::fill_t      fill;
    logic                   stall;
    logic                   replay;

    fetch_pc_gen fetch_pc_gen_inst (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_redirect_en (i_redirect_en),
        .i_redirect_pc (i_redirect_pc),
        .i_stall       (stall),
        .i_replay      (replay),
        .i_rsp         (rsp),
        .o_lookup_en   (lookup_en),
        .o_lookup_addr (lookup_addr),
        .o_insn_valid  (o_insn_valid),
        .o_insn_pc     (o_insn_pc),
        .o_insn        (o_insn)
    );

    icache icache_inst (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_lookup_en   (lookup_en),
        .i_lookup_addr (lookup_addr),
        .i_fill        (fill),
        .o_rsp         (rsp),
        .o_miss_en     (miss_en),
        .o_miss_addr   (miss_addr)
    );

    // Fill path from external line memory
    icache_miss_unit icache_miss_unit_inst (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_miss_en      (miss_en),
        .i_miss_addr    (miss_addr),
        .o_mem_rd_en    (o_mem_rd_en),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .i_mem_rd_valid (i_mem_rd_valid),
        .i_mem_rd_line  (i_mem_rd_line),
        .o_fill         (fill),
        .o_stall        (stall),
        .o_replay       (replay)
    );

endmodule

// File: verilog.f
+incdir+hw
hw/icache_pkg.sv
hw/cache_array.sv
hw/icache.sv
hw/icache_miss_unit.sv
hw/fetch_pc_gen.sv
hw/ifetch_top.sv
bench/line_memory.sv
bench/ifetch_tb.sv
